/* rtl/uart_dbg_pkg.sv */
package uart_dbg_pkg;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  // One byte on the serial line
  typedef logic [7:0] byte_t;

  ////////////////////////////////////////
  // Protocol codes
  ////////////////////////////////////////

  localparam byte_t CmdRead  = 8'h11;
  localparam byte_t CmdWrite = 8'h12;
  localparam byte_t CodeAck  = 8'h06;
  localparam byte_t CodeEot  = 8'h04;

  // Address and length fields are each this many bytes, LSB first
  localparam int NumFieldBytes = 8;

  // Only the low bits of the length field are kept
  localparam int LenWidth = 16;

  ////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////

  localparam int DefClksPerBit = 8;
  localparam int DefFifoDepth  = 4;
  localparam int DefMemDepth   = 256;

endpackage

/* rtl/mem_if.sv */
`timescale 1ns/1ps

interface mem_if #(
  parameter int MemDepth = uart_dbg_pkg::DefMemDepth
) ();
  import uart_dbg_pkg::*;

  localparam int AddrWidth = $clog2(MemDepth);

  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  byte_t                wdata;
  // Valid one cycle after a read request
  byte_t                rdata;

  modport ctrl (output req, we, addr, wdata, input rdata);
  modport mem (input req, we, addr, wdata, output rdata);

endinterface

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int ClksPerBit = uart_dbg_pkg::DefClksPerBit
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                rx_i,
  output logic                valid_o,
  output uart_dbg_pkg::byte_t byte_o
);
  import uart_dbg_pkg::*;

  localparam int CntWidth = $clog2(ClksPerBit);
  // Cycles the synchronizer delays the line
  localparam int SyncLag = 2;
  localparam logic [CntWidth-1:0] HalfCnt = CntWidth'(ClksPerBit / 2 - 1);
  localparam logic [CntWidth-1:0] BitCnt  = CntWidth'(ClksPerBit - 1);
  // Stop bit is checked early to make up for the synchronizer
  localparam logic [CntWidth-1:0] StopCnt = CntWidth'(ClksPerBit - 1 - SyncLag);

  typedef enum logic [1:0] {
    StIdle,
    StStart,
    StData,
    StStop
  } state_e;

  state_e              state_q;
  logic [1:0]          sync_q;
  logic                rx_s;
  logic [CntWidth-1:0] cnt_q;
  logic [2:0]          bit_q;
  byte_t               shift_q;

  assign rx_s   = sync_q[1];
  assign byte_o = shift_q;

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= StIdle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      unique case (state_q)
        StIdle: begin
          cnt_q <= '0;
          if (!rx_s) begin
            state_q <= StStart;
          end
        end
        StStart: begin
          if (cnt_q == HalfCnt) begin
            // Glitch shorter than half a bit goes back to idle
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_s ? StIdle : StData;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        StData: begin
          if (cnt_q == BitCnt) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= StStop;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        StStop: begin
          if (cnt_q == StopCnt) begin
            // Low stop bit drops the frame
            valid_o <= rx_s;
            state_q <= StIdle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == StData && cnt_q == BitCnt) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

endmodule

/* rtl/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo #(
  parameter int FifoDepth = uart_dbg_pkg::DefFifoDepth
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  uart_dbg_pkg::byte_t push_byte_i,
  input  logic                pop_i,
  output logic                empty_o,
  output uart_dbg_pkg::byte_t head_o
);
  import uart_dbg_pkg::*;

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntWidth = $clog2(FifoDepth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(FifoDepth - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(FifoDepth);

  byte_t               entries [FifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full    = (count_q == FullCnt);
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;
  // Head is always visible while not empty
  assign head_o  = entries[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      entries[wr_ptr_q] <= push_byte_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Receiver has no back-pressure, so the engine must keep up
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i) push_i |-> !full)
    else $error("byte_fifo: push while full, byte lost");

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n_i) pop_i |-> !empty_o)
    else $error("byte_fifo: pop while empty");

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int ClksPerBit = uart_dbg_pkg::DefClksPerBit
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  uart_dbg_pkg::byte_t byte_i,
  output logic                busy_o,
  output logic                tx_o
);

  localparam int CntWidth  = $clog2(ClksPerBit);
  localparam int FrameBits = 10;
  localparam logic [CntWidth-1:0] BitCnt  = CntWidth'(ClksPerBit - 1);
  localparam logic [3:0]          LastBit = 4'(FrameBits - 1);

  // Start bit, data LSB first, stop bit
  logic [FrameBits-1:0] frame_q;
  logic [CntWidth-1:0]  cnt_q;
  logic [3:0]           bit_q;
  logic                 busy_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_q <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b0;
    end else if (start_i && !busy_q) begin
      frame_q <= {1'b1, byte_i, 1'b0};
      cnt_q   <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b1;
    end else if (busy_q) begin
      if (cnt_q == BitCnt) begin
        cnt_q   <= '0;
        // Shift in ones so the line idles high afterwards
        frame_q <= {1'b1, frame_q[FrameBits-1:1]};
        bit_q   <= bit_q + 1'b1;
        if (bit_q == LastBit) begin
          busy_q <= 1'b0;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign tx_o   = frame_q[0];
  assign busy_o = busy_q;

  // Engine waits for the stop bit before the next byte
  a_start_when_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    start_i |-> !busy_o)
    else $error("uart_tx: start while a frame is on the line");

endmodule

/* rtl/dbg_cmd_engine.sv */
`timescale 1ns/1ps

module dbg_cmd_engine #(
  parameter int MemDepth = uart_dbg_pkg::DefMemDepth
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                fifo_empty_i,
  input  uart_dbg_pkg::byte_t fifo_byte_i,
  output logic                fifo_pop_o,
  input  logic                tx_busy_i,
  output logic                tx_start_o,
  output uart_dbg_pkg::byte_t tx_byte_o,
  mem_if.ctrl                 mem
);
  import uart_dbg_pkg::*;

  localparam int AddrWidth = $clog2(MemDepth);
  localparam int HdrBytes  = 2 * NumFieldBytes;
  localparam int IdxWidth  = $clog2(HdrBytes);
  localparam logic [IdxWidth-1:0]  LastIdx  = IdxWidth'(HdrBytes - 1);
  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(MemDepth - 1);

  typedef enum logic [2:0] {
    StIdle,
    StHdr,
    StSend,
    StWrite,
    StReadReq,
    StReadData,
    StEot
  } state_e;

  state_e               state_q;
  // State to enter once the pending reply byte has gone out
  state_e               ret_q;
  logic [IdxWidth-1:0]  hdr_idx_q;
  logic                 is_read_q;
  logic [AddrWidth-1:0] addr_q;
  logic [AddrWidth-1:0] addr_next;
  logic [LenWidth-1:0]  len_q;
  byte_t                tx_byte_q;
  logic                 has_byte;
  logic                 last_byte;

  assign has_byte  = !fifo_empty_i;
  assign last_byte = (len_q == LenWidth'(1));
  assign addr_next = (addr_q == LastAddr) ? '0 : addr_q + 1'b1;

  assign fifo_pop_o = has_byte && (state_q inside {StIdle, StHdr, StWrite});
  assign tx_start_o = (state_q == StSend) && !tx_busy_i;
  assign tx_byte_o  = tx_byte_q;

  // Write data goes straight from the FIFO head to memory
  assign mem.req   = (state_q == StReadReq) || (state_q == StWrite && has_byte);
  assign mem.we    = (state_q == StWrite);
  assign mem.addr  = addr_q;
  assign mem.wdata = fifo_byte_i;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= StIdle;
      ret_q     <= StIdle;
      hdr_idx_q <= '0;
      is_read_q <= 1'b0;
      len_q     <= '0;
    end else begin
      unique case (state_q)
        StIdle: begin
          if (has_byte) begin
            if (fifo_byte_i == CodeAck) begin
              ret_q   <= StIdle;
              state_q <= StSend;
            end else if (fifo_byte_i == CmdRead || fifo_byte_i == CmdWrite) begin
              is_read_q <= (fifo_byte_i == CmdRead);
              hdr_idx_q <= '0;
              state_q   <= StHdr;
            end
          end
        end
        StHdr: begin
          if (has_byte) begin
            // Low length bytes follow the address field
            for (int b = 0; b < LenWidth; b++) begin
              if (hdr_idx_q == IdxWidth'(NumFieldBytes + b / 8)) begin
                len_q[b] <= fifo_byte_i[b % 8];
              end
            end
            hdr_idx_q <= hdr_idx_q + 1'b1;
            if (hdr_idx_q == LastIdx) begin
              ret_q   <= (len_q == '0) ? StEot : (is_read_q ? StReadReq : StWrite);
              state_q <= StSend;
            end
          end
        end
        StSend: begin
          if (!tx_busy_i) begin
            state_q <= ret_q;
          end
        end
        StWrite: begin
          if (has_byte) begin
            len_q <= len_q - 1'b1;
            if (last_byte) begin
              state_q <= StEot;
            end
          end
        end
        StReadReq: state_q <= StReadData;
        StReadData: begin
          len_q   <= len_q - 1'b1;
          ret_q   <= last_byte ? StEot : StReadReq;
          state_q <= StSend;
        end
        StEot: begin
          ret_q   <= StIdle;
          state_q <= StSend;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Address and reply byte
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state_q)
      StIdle: begin
        if (has_byte) begin
          tx_byte_q <= CodeAck;
        end
      end
      StHdr: begin
        if (has_byte) begin
          // Upper address bytes do not reach the memory
          for (int b = 0; b < AddrWidth; b++) begin
            if (hdr_idx_q == IdxWidth'(b / 8)) begin
              addr_q[b] <= fifo_byte_i[b % 8];
            end
          end
          tx_byte_q <= CodeAck;
        end
      end
      StWrite: begin
        if (has_byte) begin
          addr_q <= addr_next;
        end
      end
      StReadData: begin
        tx_byte_q <= mem.rdata;
        addr_q    <= addr_next;
      end
      StEot: tx_byte_q <= CodeEot;
      default: ;
    endcase
  end

endmodule

/* rtl/dbg_mem.sv */
`timescale 1ns/1ps

module dbg_mem #(
  parameter int MemDepth = uart_dbg_pkg::DefMemDepth
) (
  input logic clk,
  mem_if.mem  mem
);
  import uart_dbg_pkg::*;

  byte_t storage [MemDepth];
  byte_t rdata_q;

  // Write lands at the request edge, read data one cycle later
  always_ff @(posedge clk) begin
    if (mem.req) begin
      if (mem.we) begin
        storage[mem.addr] <= mem.wdata;
      end else begin
        rdata_q <= storage[mem.addr];
      end
    end
  end

  assign mem.rdata = rdata_q;

  // Engine must wrap its address before it reaches the array
  a_addr_range: assert property (@(posedge clk) mem.req |-> (int'(mem.addr) < MemDepth))
    else $error("dbg_mem: address %0d out of range", mem.addr);

endmodule

/* rtl/uart_dbg_top.sv */
`timescale 1ns/1ps

module uart_dbg_top #(
  parameter int ClksPerBit = uart_dbg_pkg::DefClksPerBit,
  parameter int FifoDepth  = uart_dbg_pkg::DefFifoDepth,
  parameter int MemDepth   = uart_dbg_pkg::DefMemDepth
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);
  import uart_dbg_pkg::*;

  logic  rx_valid;
  byte_t rx_byte;
  logic  fifo_empty;
  logic  fifo_pop;
  byte_t fifo_head;
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;

  mem_if #(.MemDepth(MemDepth)) u_mem_if ();

  ////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////

  uart_rx #(.ClksPerBit(ClksPerBit)) u_uart_rx (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .rx_i     (uart_rx_i),
    .valid_o  (rx_valid),
    .byte_o   (rx_byte)
  );

  byte_fifo #(.FifoDepth(FifoDepth)) u_byte_fifo (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .push_i      (rx_valid),
    .push_byte_i (rx_byte),
    .pop_i       (fifo_pop),
    .empty_o     (fifo_empty),
    .head_o      (fifo_head)
  );

  ////////////////////////////////////////
  // Engine, memory and transmit path
  ////////////////////////////////////////

  dbg_cmd_engine #(.MemDepth(MemDepth)) u_engine (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .fifo_empty_i (fifo_empty),
    .fifo_byte_i  (fifo_head),
    .fifo_pop_o   (fifo_pop),
    .tx_busy_i    (tx_busy),
    .tx_start_o   (tx_start),
    .tx_byte_o    (tx_byte),
    .mem          (u_mem_if.ctrl)
  );

  dbg_mem #(.MemDepth(MemDepth)) u_mem (
    .clk (clk),
    .mem (u_mem_if.mem)
  );

  uart_tx #(.ClksPerBit(ClksPerBit)) u_uart_tx (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (tx_start),
    .byte_i   (tx_byte),
    .busy_o   (tx_busy),
    .tx_o     (uart_tx_o)
  );

endmodule

/* tests/tb_uart_dbg.sv */
`timescale 1ns/1ps

module tb_uart_dbg;
  import uart_dbg_pkg::*;

  localparam int ClksPerBit = DefClksPerBit;
  localparam int FifoDepth  = DefFifoDepth;
  localparam int MemDepth   = DefMemDepth;

  localparam logic [31:0] Seed = 32'had4b;
  localparam int NumPairs = 12;
  localparam int MaxBurst = 16;
  // Idle time after each command in byte frames
  localparam int GapBytes = 2;
  // Worst case per command covers header, burst, two codes and the idle gap
  localparam int CmdBytes = 1 + 2 * NumFieldBytes + MaxBurst + 2 + GapBytes;
  localparam int NumCmds  = 2 * NumPairs + 6;
  localparam int TimeoutCycles = (NumCmds * CmdBytes + 8) * 10 * ClksPerBit * 2;

  logic clk;
  logic arst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;

  logic [31:0] lfsr_q = Seed;
  int          cycle_cnt = 0;
  byte_t       reply_q [$];
  // Reference memory that is valid only where the host has written
  byte_t       model_mem [MemDepth];
  logic        model_valid [MemDepth];
  logic [63:0] wr_addr [NumPairs];
  int          wr_len [NumPairs];

  uart_dbg_top #(
    .ClksPerBit (ClksPerBit),
    .FifoDepth  (FifoDepth),
    .MemDepth   (MemDepth)
  ) u_dut (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: the DUT did not finish within %0d cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped by the watchdog");
    end
  end

  ////////////////////////////////////////
  // Random numbers and checks
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic check_eq(input logic [63:0] expected, input logic [63:0] actual,
                          input string what);
    if (expected !== actual) begin
      $display("FAIL at %0t: %s, expected 0x%0h, got 0x%0h", $time, what, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch, simulation stopped");
    end
  endtask

  function automatic int mem_index(input logic [63:0] addr, input int i);
    return int'((addr + 64'(i)) % 64'(MemDepth));
  endfunction

  function automatic byte_t pop_reply();
    return reply_q.pop_front();
  endfunction

  ////////////////////////////////////////
  // Host side of the serial line
  ////////////////////////////////////////

  // 8N1 with the LSB first
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < NumFieldBytes; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  task automatic send_header(input byte_t cmd, input logic [63:0] addr,
                             input logic [63:0] len);
    send_byte(cmd);
    send_field(addr);
    send_field(len);
  endtask

  task automatic wait_bytes(input int n);
    while (reply_q.size() < n) begin
      @(posedge clk);
    end
  endtask

  // Nothing more may arrive once a reply is complete
  task automatic quiet_gap();
    repeat (GapBytes * 10 * ClksPerBit) @(posedge clk);
    check_eq(64'(0), 64'(reply_q.size()), "reply bytes beyond the expected count");
  endtask

  // Samples mid-bit on the falling edge away from the DUT's updates
  initial begin : line_monitor
    byte_t data;
    forever begin
      @(negedge clk);
      if (arst_n_i && !uart_tx_o) begin
        repeat (ClksPerBit / 2) @(negedge clk);
        check_eq(64'(0), 64'(uart_tx_o), "start bit on uart_tx_o");
        for (int i = 0; i < 8; i++) begin
          repeat (ClksPerBit) @(negedge clk);
          data[i] = uart_tx_o;
        end
        repeat (ClksPerBit) @(negedge clk);
        check_eq(64'(1), 64'(uart_tx_o), "stop bit on uart_tx_o");
        reply_q.push_back(data);
      end
    end
  end

  ////////////////////////////////////////
  // Protocol transactions
  ////////////////////////////////////////

  task automatic ack_challenge();
    send_byte(CodeAck);
    wait_bytes(1);
    check_eq(64'(CodeAck), 64'(pop_reply()), "reply to ACK challenge");
    quiet_gap();
  endtask

  task automatic write_block(input logic [63:0] addr, input int len);
    byte_t b;
    int    idx;
    send_header(CmdWrite, addr, 64'(len));
    // Data goes out only after the header is acknowledged
    wait_bytes(1);
    check_eq(64'(CodeAck), 64'(pop_reply()), "ACK after write header");
    for (int i = 0; i < len; i++) begin
      b   = byte_t'(rand_bits(8));
      idx = mem_index(addr, i);
      send_byte(b);
      model_mem[idx]   = b;
      model_valid[idx] = 1'b1;
    end
    wait_bytes(1);
    check_eq(64'(CodeEot), 64'(pop_reply()), "EOT after write data");
    quiet_gap();
  endtask

  task automatic read_block(input logic [63:0] addr, input int len);
    byte_t b;
    int    idx;
    send_header(CmdRead, addr, 64'(len));
    wait_bytes(len + 2);
    check_eq(64'(CodeAck), 64'(pop_reply()), "ACK after read header");
    for (int i = 0; i < len; i++) begin
      b   = pop_reply();
      idx = mem_index(addr, i);
      if (model_valid[idx]) begin
        check_eq(64'(model_mem[idx]), 64'(b), $sformatf("read data at address 0x%0h", idx));
      end
    end
    check_eq(64'(CodeEot), 64'(pop_reply()), "EOT after read data");
    quiet_gap();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    logic [63:0] addr;
    byte_t       junk;
    arst_n_i  = 1'b0;
    uart_rx_i = 1'b1;
    for (int i = 0; i < MemDepth; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;

    // Line stays idle while the host is silent
    repeat (20) begin
      @(negedge clk);
      check_eq(64'(1), 64'(uart_tx_o), "idle level of uart_tx_o after reset");
    end

    ack_challenge();

    // Random bursts are all written before any is read back
    for (int n = 0; n < NumPairs; n++) begin
      wr_addr[n][63:32] = rand_bits(32);
      wr_addr[n][31:0]  = rand_bits(32);
      wr_len[n]         = 1 + int'(rand_bits(4));
      write_block(wr_addr[n], wr_len[n]);
    end
    for (int n = 0; n < NumPairs; n++) begin
      read_block(wr_addr[n], wr_len[n]);
    end

    // Burst across the top of memory and read back at the wrapped address
    addr = 64'(3 * MemDepth) - 64'(1) - 64'(rand_bits(3));
    write_block(addr, MaxBurst);
    read_block(addr % 64'(MemDepth), MaxBurst);

    addr[63:32] = rand_bits(32);
    addr[31:0]  = rand_bits(32);
    read_block(addr, 0);

    // Stray bytes in idle get no answer
    for (int n = 0; n < 3; n++) begin
      junk = byte_t'(rand_bits(8));
      while (junk inside {CodeAck, CmdRead, CmdWrite}) begin
        junk = byte_t'(rand_bits(8));
      end
      send_byte(junk);
    end
    quiet_gap();
    ack_challenge();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* sources.f */
rtl/uart_dbg_pkg.sv
rtl/mem_if.sv
rtl/uart_rx.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/dbg_cmd_engine.sv
rtl/dbg_mem.sv
rtl/uart_dbg_top.sv
tests/tb_uart_dbg.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -sv
TOP      ?= tb_uart_dbg
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
